//--- src/qit_pkg.sv
`default_nettype none

package qit_pkg;

	// ==============================
	// sizes
	// ==============================

	localparam int NUM_TIMERS = 4;
	localparam int TIMER_BITS = 16;
	// bus data must hold a full count and a full control byte
	localparam int DATA_BITS = 32;
	// word address, timers in the low half, globals from 32 up
	localparam int ADDR_BITS = 6;
	// stored control field, bits 0 to 4
	localparam int CTRL_BITS = 5;

	// ==============================
	// register map
	// ==============================

	// per-timer offsets, timer n sits at 4n .. 4n+3
	localparam logic [1:0] REG_COUNT = 2'd0;
	localparam logic [1:0] REG_MAX = 2'd1;
	localparam logic [1:0] REG_ONTIME = 2'd2;
	localparam logic [1:0] REG_CTRL = 2'd3;

	// global words
	localparam logic [ADDR_BITS-1:0] REG_UNDERFLOW = 6'd32;
	localparam logic [ADDR_BITS-1:0] REG_SYNC = 6'd33;
	localparam logic [ADDR_BITS-1:0] REG_IE = 6'd34;
	localparam logic [ADDR_BITS-1:0] REG_OUTSTAT = 6'd35;
	localparam logic [ADDR_BITS-1:0] REG_IGATE = 6'd36;
	localparam logic [ADDR_BITS-1:0] REG_IGATE_SET = 6'd37;
	localparam logic [ADDR_BITS-1:0] REG_IGATE_CLR = 6'd38;

	// control bits
	localparam int CTRL_LD = 0;
	localparam int CTRL_CE = 1;
	localparam int CTRL_AR = 2;
	localparam int CTRL_XC = 3;
	localparam int CTRL_GE = 4;
	// write-only, transfer at once
	localparam int CTRL_NOW = 7;

endpackage

`default_nettype wire

//--- src/qit_regs.sv
`timescale 1ns/100ps
`default_nettype none

module qit_regs (
	input  wire clk,
	input  wire rst,
	input  wire req_i,
	input  wire we_i,
	input  wire [qit_pkg::ADDR_BITS-1:0] addr_i,
	input  wire [qit_pkg::DATA_BITS-1:0] wdata_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0][qit_pkg::TIMER_BITS-1:0] count_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0][qit_pkg::TIMER_BITS-1:0] max_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0][qit_pkg::TIMER_BITS-1:0] ontime_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0] out_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0] uf_set_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0][qit_pkg::CTRL_BITS-1:0] ctrl_i,
	output logic ack_o,
	output logic [qit_pkg::DATA_BITS-1:0] rdata_o,
	output logic [qit_pkg::NUM_TIMERS-1:0] wr_max_o,
	output logic [qit_pkg::NUM_TIMERS-1:0] wr_ontime_o,
	output logic [qit_pkg::NUM_TIMERS-1:0] wr_ctrl_o,
	output logic [qit_pkg::DATA_BITS-1:0] wr_data_o,
	output logic [qit_pkg::NUM_TIMERS-1:0] xfer_o,
	output logic [qit_pkg::NUM_TIMERS-1:0] igate_o,
	output logic irq_o
);

	logic [qit_pkg::NUM_TIMERS-1:0] underflow;
	logic [qit_pkg::NUM_TIMERS-1:0] irqf;
	logic [qit_pkg::NUM_TIMERS-1:0] ie;
	logic [qit_pkg::NUM_TIMERS-1:0] igate;
	// one bit per timer whose word group matches the address
	logic [qit_pkg::NUM_TIMERS-1:0] tsel;
	logic [qit_pkg::NUM_TIMERS-1:0] wdata_t;
	logic [qit_pkg::NUM_TIMERS-1:0] uf_clr;
	logic [qit_pkg::DATA_BITS-1:0] rd_word;
	logic wr;
	logic rd;

	assign wr = req_i & we_i;
	assign rd = req_i & ~we_i;
	assign wdata_t = wdata_i[qit_pkg::NUM_TIMERS-1:0];
	assign wr_data_o = wdata_i;
	assign igate_o = igate;
	assign irq_o = |irqf;
	assign uf_clr = (wr && addr_i == qit_pkg::REG_UNDERFLOW) ? wdata_t : '0;

	// ==============================
	// write decode
	// ==============================

	always_comb begin
		for (int i = 0; i < qit_pkg::NUM_TIMERS; i++) begin
			// globals start at group 8, so they never hit a timer
			tsel[i] = addr_i[qit_pkg::ADDR_BITS-1:2] == (qit_pkg::ADDR_BITS-2)'(i);
			wr_max_o[i] = wr & tsel[i] & (addr_i[1:0] == qit_pkg::REG_MAX);
			wr_ontime_o[i] = wr & tsel[i] & (addr_i[1:0] == qit_pkg::REG_ONTIME);
			wr_ctrl_o[i] = wr & tsel[i] & (addr_i[1:0] == qit_pkg::REG_CTRL);
			// transfer by sync word or by a control write with the now bit
			xfer_o[i] = (wr & (addr_i == qit_pkg::REG_SYNC) & wdata_t[i])
				| (wr & tsel[i] & (addr_i[1:0] == qit_pkg::REG_CTRL)
				& wdata_i[qit_pkg::CTRL_NOW]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			underflow <= '0;
			irqf <= '0;
			ie <= '0;
			igate <= '0;
			ack_o <= 1'b0;
		end else begin
			ack_o <= req_i;
			// set wins over a clear in the same cycle
			underflow <= (underflow & ~uf_clr) | uf_set_i;
			irqf <= (irqf & ~uf_clr) | (uf_set_i & ie);
			ie <= ie & ~uf_clr;
			if (wr) begin
				case (addr_i)
					qit_pkg::REG_IE: ie <= wdata_t;
					qit_pkg::REG_IGATE: igate <= wdata_t;
					qit_pkg::REG_IGATE_SET: igate <= igate | wdata_t;
					qit_pkg::REG_IGATE_CLR: igate <= igate & ~wdata_t;
					default: ;
				endcase
			end
		end
	end

	// ==============================
	// read-back
	// ==============================

	always_comb begin
		rd_word = '0;
		for (int i = 0; i < qit_pkg::NUM_TIMERS; i++) begin
			if (tsel[i]) begin
				case (addr_i[1:0])
					qit_pkg::REG_COUNT: rd_word[qit_pkg::TIMER_BITS-1:0] = count_i[i];
					qit_pkg::REG_MAX: rd_word[qit_pkg::TIMER_BITS-1:0] = max_i[i];
					qit_pkg::REG_ONTIME: rd_word[qit_pkg::TIMER_BITS-1:0] = ontime_i[i];
					qit_pkg::REG_CTRL: rd_word[qit_pkg::CTRL_BITS-1:0] = ctrl_i[i];
					default: ;
				endcase
			end
		end
		// sync and the gate aliases read as zero
		case (addr_i)
			qit_pkg::REG_UNDERFLOW: rd_word[qit_pkg::NUM_TIMERS-1:0] = underflow;
			qit_pkg::REG_IE: rd_word[qit_pkg::NUM_TIMERS-1:0] = ie;
			qit_pkg::REG_OUTSTAT: rd_word[qit_pkg::NUM_TIMERS-1:0] = out_i;
			qit_pkg::REG_IGATE: rd_word[qit_pkg::NUM_TIMERS-1:0] = igate;
			default: ;
		endcase
	end

	// data only with a read's ack
	always_ff @(posedge clk) begin
		rdata_o <= rd ? rd_word : '0;
	end

endmodule

`default_nettype wire

//--- src/qit_shadow.sv
`timescale 1ns/100ps
`default_nettype none

module qit_shadow (
	input  wire clk,
	input  wire rst,
	input  wire [qit_pkg::NUM_TIMERS-1:0] wr_max_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0] wr_ontime_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0] wr_ctrl_i,
	input  wire [qit_pkg::DATA_BITS-1:0] wr_data_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0] xfer_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0] stop_i,
	output logic [qit_pkg::NUM_TIMERS-1:0][qit_pkg::TIMER_BITS-1:0] max_o,
	output logic [qit_pkg::NUM_TIMERS-1:0][qit_pkg::TIMER_BITS-1:0] ontime_o,
	output logic [qit_pkg::NUM_TIMERS-1:0] ce_o,
	output logic [qit_pkg::NUM_TIMERS-1:0] ar_o,
	output logic [qit_pkg::NUM_TIMERS-1:0] xc_o,
	output logic [qit_pkg::NUM_TIMERS-1:0] ge_o,
	output logic [qit_pkg::NUM_TIMERS-1:0] load_o
);

	logic [qit_pkg::NUM_TIMERS-1:0][qit_pkg::TIMER_BITS-1:0] hold_max;
	logic [qit_pkg::NUM_TIMERS-1:0][qit_pkg::TIMER_BITS-1:0] hold_ontime;
	logic [qit_pkg::NUM_TIMERS-1:0][qit_pkg::CTRL_BITS-1:0] hold_ctrl;
	// transfer is taken one cycle late so a now-write sees its own control
	logic [qit_pkg::NUM_TIMERS-1:0] xfer_q;

	// holding values
	always_ff @(posedge clk) begin
		for (int i = 0; i < qit_pkg::NUM_TIMERS; i++) begin
			if (wr_max_i[i])
				hold_max[i] <= wr_data_i[qit_pkg::TIMER_BITS-1:0];
			if (wr_ontime_i[i])
				hold_ontime[i] <= wr_data_i[qit_pkg::TIMER_BITS-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			xfer_q <= '0;
			load_o <= '0;
			max_o <= '0;
			ontime_o <= '0;
			ce_o <= '0;
			ar_o <= '1;
			xc_o <= '0;
			ge_o <= '0;
			for (int i = 0; i < qit_pkg::NUM_TIMERS; i++)
				hold_ctrl[i] <= qit_pkg::CTRL_BITS'(1 << qit_pkg::CTRL_AR);
		end else begin
			xfer_q <= xfer_i;
			for (int i = 0; i < qit_pkg::NUM_TIMERS; i++) begin
				load_o[i] <= 1'b0;
				// one-shot terminal count, a transfer below overrides it
				if (stop_i[i])
					ce_o[i] <= 1'b0;
				if (xfer_q[i]) begin
					max_o[i] <= hold_max[i];
					ontime_o[i] <= hold_ontime[i];
					ce_o[i] <= hold_ctrl[i][qit_pkg::CTRL_CE];
					ar_o[i] <= hold_ctrl[i][qit_pkg::CTRL_AR];
					xc_o[i] <= hold_ctrl[i][qit_pkg::CTRL_XC];
					ge_o[i] <= hold_ctrl[i][qit_pkg::CTRL_GE];
					load_o[i] <= hold_ctrl[i][qit_pkg::CTRL_LD];
					// load is a one-time request
					hold_ctrl[i][qit_pkg::CTRL_LD] <= 1'b0;
				end
				if (wr_ctrl_i[i])
					hold_ctrl[i] <= wr_data_i[qit_pkg::CTRL_BITS-1:0];
			end
		end
	end

endmodule

`default_nettype wire

//--- src/qit_tick.sv
`timescale 1ns/100ps
`default_nettype none

module qit_tick (
	input  wire clk,
	input  wire rst,
	input  wire [qit_pkg::NUM_TIMERS-1:0] ext_clk_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0] ext_gate_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0] igate_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0] ce_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0] xc_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0] ge_i,
	output logic [qit_pkg::NUM_TIMERS-1:0] step_o
);

	// two-flop synchronizers plus one stage for the edge
	logic [qit_pkg::NUM_TIMERS-1:0] clk_s1;
	logic [qit_pkg::NUM_TIMERS-1:0] clk_s2;
	logic [qit_pkg::NUM_TIMERS-1:0] clk_s3;
	logic [qit_pkg::NUM_TIMERS-1:0] gate_s1;
	logic [qit_pkg::NUM_TIMERS-1:0] gate_s2;
	logic [qit_pkg::NUM_TIMERS-1:0] ext_edge;

	always_ff @(posedge clk) begin
		if (rst) begin
			clk_s1 <= '0;
			clk_s2 <= '0;
			clk_s3 <= '0;
			gate_s1 <= '0;
			gate_s2 <= '0;
		end else begin
			clk_s1 <= ext_clk_i;
			clk_s2 <= clk_s1;
			clk_s3 <= clk_s2;
			gate_s1 <= ext_gate_i;
			gate_s2 <= gate_s1;
		end
	end

	// rising edge in the system clock domain
	assign ext_edge = clk_s2 & ~clk_s3;

	// enable, then clock source, then gating
	assign step_o = ce_i & (~xc_i | ext_edge) & (~ge_i | (gate_s2 & igate_i));

endmodule

`default_nettype wire

//--- src/qit_counters.sv
`timescale 1ns/100ps
`default_nettype none

module qit_counters (
	input  wire clk,
	input  wire rst,
	input  wire [qit_pkg::NUM_TIMERS-1:0] step_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0] load_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0][qit_pkg::TIMER_BITS-1:0] max_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0][qit_pkg::TIMER_BITS-1:0] ontime_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0] ar_i,
	output logic [qit_pkg::NUM_TIMERS-1:0][qit_pkg::TIMER_BITS-1:0] count_o,
	output logic [qit_pkg::NUM_TIMERS-1:0] out_o,
	output logic [qit_pkg::NUM_TIMERS-1:0] uf_set_o,
	output logic [qit_pkg::NUM_TIMERS-1:0] stop_o
);

	logic [qit_pkg::NUM_TIMERS-1:0] at_zero;
	logic [qit_pkg::NUM_TIMERS-1:0] at_ontime;

	// ==============================
	// terminal count
	// ==============================

	always_comb begin
		for (int i = 0; i < qit_pkg::NUM_TIMERS; i++) begin
			at_zero[i] = count_o[i] == '0;
			at_ontime[i] = count_o[i] == ontime_i[i];
		end
	end

	// a step that finds zero underflows, load takes the cycle instead
	assign uf_set_o = step_i & ~load_i & at_zero;
	// without auto-reload the shadow drops ce in the same edge
	assign stop_o = uf_set_o & ~ar_i;

	// ==============================
	// counters
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			count_o <= '0;
			out_o <= '0;
		end else begin
			for (int i = 0; i < qit_pkg::NUM_TIMERS; i++) begin
				if (load_i[i]) begin
					count_o[i] <= max_i[i];
					// new period starts with the output low
					out_o[i] <= 1'b0;
				end else if (step_i[i]) begin
					if (at_zero[i]) begin
						out_o[i] <= 1'b0;
						// one-shot stays at zero
						if (ar_i[i])
							count_o[i] <= max_i[i];
					end else begin
						if (at_ontime[i])
							out_o[i] <= 1'b1;
						count_o[i] <= count_o[i] - 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- src/qit_top.sv
`timescale 1ns/100ps
`default_nettype none

module qit_top (
	input  wire clk,
	input  wire rst,
	input  wire req_i,
	input  wire we_i,
	input  wire [qit_pkg::ADDR_BITS-1:0] addr_i,
	input  wire [qit_pkg::DATA_BITS-1:0] wdata_i,
	output logic ack_o,
	output logic [qit_pkg::DATA_BITS-1:0] rdata_o,
	input  wire [qit_pkg::NUM_TIMERS-1:0] ext_clk_i,
	input  wire [qit_pkg::NUM_TIMERS-1:0] ext_gate_i,
	output logic [qit_pkg::NUM_TIMERS-1:0] tmr_out_o,
	output logic irq_o
);

	// register interface to shadow
	logic [qit_pkg::NUM_TIMERS-1:0] wr_max;
	logic [qit_pkg::NUM_TIMERS-1:0] wr_ontime;
	logic [qit_pkg::NUM_TIMERS-1:0] wr_ctrl;
	logic [qit_pkg::DATA_BITS-1:0] wr_data;
	logic [qit_pkg::NUM_TIMERS-1:0] xfer;
	logic [qit_pkg::NUM_TIMERS-1:0] igate;
	// active settings
	logic [qit_pkg::NUM_TIMERS-1:0][qit_pkg::TIMER_BITS-1:0] max;
	logic [qit_pkg::NUM_TIMERS-1:0][qit_pkg::TIMER_BITS-1:0] ontime;
	logic [qit_pkg::NUM_TIMERS-1:0] ce;
	logic [qit_pkg::NUM_TIMERS-1:0] ar;
	logic [qit_pkg::NUM_TIMERS-1:0] xc;
	logic [qit_pkg::NUM_TIMERS-1:0] ge;
	logic [qit_pkg::NUM_TIMERS-1:0] load;
	logic [qit_pkg::NUM_TIMERS-1:0][qit_pkg::CTRL_BITS-1:0] ctrl;
	// counter side
	logic [qit_pkg::NUM_TIMERS-1:0] step;
	logic [qit_pkg::NUM_TIMERS-1:0] stop;
	logic [qit_pkg::NUM_TIMERS-1:0] uf_set;
	logic [qit_pkg::NUM_TIMERS-1:0][qit_pkg::TIMER_BITS-1:0] count;

	// control read-back, load is never stored
	for (genvar i = 0; i < qit_pkg::NUM_TIMERS; i++) begin : g_ctrl
		assign ctrl[i][qit_pkg::CTRL_LD] = 1'b0;
		assign ctrl[i][qit_pkg::CTRL_CE] = ce[i];
		assign ctrl[i][qit_pkg::CTRL_AR] = ar[i];
		assign ctrl[i][qit_pkg::CTRL_XC] = xc[i];
		assign ctrl[i][qit_pkg::CTRL_GE] = ge[i];
	end

	qit_regs u_regs (
		.clk(clk), .rst(rst), .req_i(req_i), .we_i(we_i), .addr_i(addr_i),
		.wdata_i(wdata_i), .count_i(count), .max_i(max), .ontime_i(ontime),
		.out_i(tmr_out_o), .uf_set_i(uf_set), .ctrl_i(ctrl), .ack_o(ack_o),
		.rdata_o(rdata_o), .wr_max_o(wr_max), .wr_ontime_o(wr_ontime),
		.wr_ctrl_o(wr_ctrl), .wr_data_o(wr_data), .xfer_o(xfer), .igate_o(igate),
		.irq_o(irq_o)
	);

	qit_shadow u_shadow (
		.clk(clk), .rst(rst), .wr_max_i(wr_max), .wr_ontime_i(wr_ontime),
		.wr_ctrl_i(wr_ctrl), .wr_data_i(wr_data), .xfer_i(xfer), .stop_i(stop),
		.max_o(max), .ontime_o(ontime), .ce_o(ce), .ar_o(ar), .xc_o(xc),
		.ge_o(ge), .load_o(load)
	);

	qit_tick u_tick (
		.clk(clk), .rst(rst), .ext_clk_i(ext_clk_i), .ext_gate_i(ext_gate_i),
		.igate_i(igate), .ce_i(ce), .xc_i(xc), .ge_i(ge), .step_o(step)
	);

	qit_counters u_counters (
		.clk(clk), .rst(rst), .step_i(step), .load_i(load), .max_i(max),
		.ontime_i(ontime), .ar_i(ar), .count_o(count), .out_o(tmr_out_o),
		.uf_set_o(uf_set), .stop_o(stop)
	);

endmodule

`default_nettype wire

//--- test/qit_model.svh
`ifndef QIT_MODEL_SVH
`define QIT_MODEL_SVH

// ==============================
// reference model
// ==============================

// word address of a per-timer register, timer n at 4n
function automatic logic [qit_pkg::ADDR_BITS-1:0] timer_addr(input int n, input int off);
	return qit_pkg::ADDR_BITS'(4 * n + off);
endfunction

// control word as software writes it
function automatic logic [31:0] ctrl_word(input bit ld, input bit ce, input bit ar,
		input bit xc, input bit ge, input bit now);
	logic [31:0] w;
	w = '0;
	w[qit_pkg::CTRL_LD] = ld;
	w[qit_pkg::CTRL_CE] = ce;
	w[qit_pkg::CTRL_AR] = ar;
	w[qit_pkg::CTRL_XC] = xc;
	w[qit_pkg::CTRL_GE] = ge;
	w[qit_pkg::CTRL_NOW] = now;
	return w;
endfunction

// steps from max down through zero
function automatic int expected_period(input int max);
	return max + 1;
endfunction

// count after a number of steps since load
function automatic int expected_count(input int steps, input int max, input bit ar);
	if (ar)
		return max - (steps % expected_period(max));
	// one-shot parks at zero
	if (steps >= max)
		return 0;
	return max - steps;
endfunction

// output level after a number of steps since load
function automatic bit expected_out(input int steps, input int max, input int ontime);
	int pos;
	pos = steps % expected_period(max);
	// zero on time is overridden by terminal count
	if (ontime == 0 || ontime > max)
		return 1'b0;
	// high once the count has passed the on time, low again at reload
	return pos > max - ontime;
endfunction

`endif

//--- test/qit_tb.sv
`timescale 1ns/100ps
`default_nettype none

module qit_tb;

	// ==============================
	// run length
	// ==============================

	// rough cycle budget per test
	localparam int T_READBACK = 80;
	localparam int T_ONESHOT = 80;
	localparam int T_IRQ = 100;
	localparam int T_EXTCLK = 100;
	localparam int T_GATE = 120;
	localparam int T_SYNC = 60;
	// watchdog at twice the summed budget
	localparam int TIMEOUT_CYCLES =
		2 * (3 + T_READBACK + T_ONESHOT + T_IRQ + T_EXTCLK + T_GATE + T_SYNC);
	// ext clock high and low time in system cycles
	localparam int EXT_HALF = 4;
	localparam int EXT_EDGES = 6;

	logic clk;
	logic rst;
	logic req_i;
	logic we_i;
	logic [qit_pkg::ADDR_BITS-1:0] addr_i;
	logic [qit_pkg::DATA_BITS-1:0] wdata_i;
	logic ack_o;
	logic [qit_pkg::DATA_BITS-1:0] rdata_o;
	logic [qit_pkg::NUM_TIMERS-1:0] ext_clk_i;
	logic [qit_pkg::NUM_TIMERS-1:0] ext_gate_i;
	logic [qit_pkg::NUM_TIMERS-1:0] tmr_out_o;
	logic irq_o;

	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int tests = 0;

	`include "qit_model.svh"

	qit_top dut (
		.clk(clk), .rst(rst), .req_i(req_i), .we_i(we_i), .addr_i(addr_i),
		.wdata_i(wdata_i), .ack_o(ack_o), .rdata_o(rdata_o), .ext_clk_i(ext_clk_i),
		.ext_gate_i(ext_gate_i), .tmr_out_o(tmr_out_o), .irq_o(irq_o)
	);

	// 20 ns period
	always #10 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

	// ==============================
	// helpers
	// ==============================

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s, got 0x%0h expected 0x%0h", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors == err_before)
			$display("test %0d, %s: ok", tests, name);
		else
			$display("test %0d, %s: %0d mismatches", tests, name, errors - err_before);
	endtask

	// single strobe, ack one cycle later
	task automatic bus_write(input logic [qit_pkg::ADDR_BITS-1:0] addr,
			input logic [31:0] data);
		@(posedge clk);
		req_i <= 1'b1;
		we_i <= 1'b1;
		addr_i <= addr;
		wdata_i <= data;
		@(posedge clk);
		req_i <= 1'b0;
		we_i <= 1'b0;
		@(negedge clk);
		check_value("ack after write", ack_o, 1'b1);
		check_value("rdata zero on write ack", rdata_o, '0);
	endtask

	task automatic bus_read(input logic [qit_pkg::ADDR_BITS-1:0] addr,
			output logic [31:0] data);
		@(posedge clk);
		req_i <= 1'b1;
		we_i <= 1'b0;
		addr_i <= addr;
		@(posedge clk);
		req_i <= 1'b0;
		@(negedge clk);
		check_value("ack after read", ack_o, 1'b1);
		data = rdata_o;
	endtask

	task automatic setup_timer(input int n, input int max, input int ontime,
			input logic [31:0] ctrl);
		bus_write(timer_addr(n, qit_pkg::REG_MAX), max);
		bus_write(timer_addr(n, qit_pkg::REG_ONTIME), ontime);
		bus_write(timer_addr(n, qit_pkg::REG_CTRL), ctrl);
	endtask

	// load lands two edges after the transfer request
	task automatic wait_load();
		repeat (3) @(posedge clk);
	endtask

	// one slow rising edge, seen after the two-flop synchronizer
	task automatic ext_pulse(input int t);
		@(posedge clk);
		ext_clk_i[t] <= 1'b1;
		repeat (EXT_HALF) @(posedge clk);
		ext_clk_i[t] <= 1'b0;
		repeat (EXT_HALF) @(posedge clk);
	endtask

	task automatic wait_irq(input int limit, output bit seen);
		seen = 1'b0;
		for (int i = 0; i < limit; i++) begin
			@(negedge clk);
			if (irq_o) begin
				seen = 1'b1;
				break;
			end
		end
	endtask

	// ==============================
	// tests
	// ==============================

	task automatic test_readback();
		int err_before;
		int mx [qit_pkg::NUM_TIMERS];
		int ot [qit_pkg::NUM_TIMERS];
		logic [31:0] rd;
		err_before = errors;
		@(negedge clk);
		check_value("tmr_out after reset", tmr_out_o, '0);
		check_value("irq after reset", irq_o, 1'b0);
		check_value("ack idle after reset", ack_o, 1'b0);
		for (int n = 0; n < qit_pkg::NUM_TIMERS; n++) begin
			mx[n] = $urandom % 65536;
			ot[n] = $urandom % 65536;
			// counter stays off, auto-reload as after reset
			setup_timer(n, mx[n], ot[n], ctrl_word(0, 0, 1, 0, 0, 1));
		end
		for (int n = 0; n < qit_pkg::NUM_TIMERS; n++) begin
			bus_read(timer_addr(n, qit_pkg::REG_MAX), rd);
			check_value($sformatf("timer %0d max read-back", n), rd, mx[n]);
			bus_read(timer_addr(n, qit_pkg::REG_ONTIME), rd);
			check_value($sformatf("timer %0d on time read-back", n), rd, ot[n]);
			bus_read(timer_addr(n, qit_pkg::REG_CTRL), rd);
			check_value($sformatf("timer %0d ctrl read-back", n), rd,
				ctrl_word(0, 0, 1, 0, 0, 0));
		end
		report_test("read-back and reset", err_before);
	endtask

	task automatic test_one_shot();
		int err_before;
		int m;
		int wait_cycles;
		logic [31:0] rd;
		err_before = errors;
		m = 5 + $urandom % 8;
		wait_cycles = 2 * expected_period(m) + 10;
		setup_timer(0, m, m / 2, ctrl_word(1, 1, 0, 0, 0, 1));
		repeat (wait_cycles) @(posedge clk);
		bus_read(timer_addr(0, qit_pkg::REG_COUNT), rd);
		check_value("one-shot count", rd, expected_count(wait_cycles, m, 1'b0));
		bus_read(qit_pkg::REG_UNDERFLOW, rd);
		check_value("one-shot underflow flag", rd[0], 1'b1);
		check_value("one-shot out low", tmr_out_o[0], 1'b0);
		bus_read(timer_addr(0, qit_pkg::REG_CTRL), rd);
		check_value("one-shot ce cleared", rd[qit_pkg::CTRL_CE], 1'b0);
		bus_write(qit_pkg::REG_UNDERFLOW, 32'h1);
		report_test("one-shot underflow", err_before);
	endtask

	task automatic test_irq();
		int err_before;
		int m;
		int t;
		bit seen;
		logic [31:0] rd;
		err_before = errors;
		t = 1;
		// period well above the few cycles of clearing traffic
		m = 20 + $urandom % 10;
		bus_write(qit_pkg::REG_IE, 1 << t);
		setup_timer(t, m, m / 2, ctrl_word(1, 1, 1, 0, 0, 1));
		wait_irq(2 * expected_period(m) + 10, seen);
		check_value("irq rises", seen, 1'b1);
		bus_read(qit_pkg::REG_UNDERFLOW, rd);
		check_value("underflow flag set", rd[t], 1'b1);
		bus_write(qit_pkg::REG_UNDERFLOW, 1 << t);
		check_value("irq cleared", irq_o, 1'b0);
		bus_read(qit_pkg::REG_UNDERFLOW, rd);
		check_value("underflow flag cleared", rd[t], 1'b0);
		bus_read(qit_pkg::REG_IE, rd);
		check_value("interrupt enable cleared", rd[t], 1'b0);
		// park it
		bus_write(timer_addr(t, qit_pkg::REG_CTRL), ctrl_word(0, 0, 1, 0, 0, 1));
		report_test("auto-reload interrupt", err_before);
	endtask

	task automatic test_ext_clock();
		int err_before;
		int m;
		int ot;
		int t;
		logic [31:0] rd;
		err_before = errors;
		t = 2;
		m = 50 + $urandom % 100;
		// out goes high a few edges in
		ot = m - 2;
		setup_timer(t, m, ot, ctrl_word(1, 1, 1, 1, 0, 1));
		wait_load();
		bus_read(timer_addr(t, qit_pkg::REG_COUNT), rd);
		check_value("ext count after load", rd, expected_count(0, m, 1'b1));
		for (int k = 1; k <= EXT_EDGES; k++) begin
			ext_pulse(t);
			@(negedge clk);
			check_value($sformatf("ext out after edge %0d", k), tmr_out_o[t],
				expected_out(k, m, ot));
		end
		bus_read(timer_addr(t, qit_pkg::REG_COUNT), rd);
		check_value("ext count after edges", rd, expected_count(EXT_EDGES, m, 1'b1));
		// same level through the output status word
		bus_read(qit_pkg::REG_OUTSTAT, rd);
		check_value("ext out status word", rd[t], expected_out(EXT_EDGES, m, ot));
		report_test("external clock", err_before);
	endtask

	task automatic test_gating();
		int err_before;
		int m;
		int t;
		logic [31:0] rd;
		err_before = errors;
		t = 3;
		m = 100 + $urandom % 100;
		bus_write(qit_pkg::REG_IGATE, 32'hf);
		bus_write(qit_pkg::REG_IGATE_CLR, 1 << t);
		bus_read(qit_pkg::REG_IGATE, rd);
		check_value("software gate after clear", rd, 32'h7);
		@(posedge clk);
		ext_gate_i[t] <= 1'b1;
		setup_timer(t, m, m / 2, ctrl_word(1, 1, 1, 1, 1, 1));
		wait_load();
		for (int k = 0; k < 3; k++)
			ext_pulse(t);
		bus_read(timer_addr(t, qit_pkg::REG_COUNT), rd);
		check_value("gated count holds", rd, expected_count(0, m, 1'b1));
		bus_write(qit_pkg::REG_IGATE_SET, 1 << t);
		bus_read(qit_pkg::REG_IGATE, rd);
		check_value("software gate after set", rd, 32'hf);
		for (int k = 0; k < 3; k++)
			ext_pulse(t);
		bus_read(timer_addr(t, qit_pkg::REG_COUNT), rd);
		check_value("count resumes", rd, expected_count(3, m, 1'b1));
		report_test("gating", err_before);
	endtask

	task automatic test_sync_start();
		int err_before;
		int mx [qit_pkg::NUM_TIMERS];
		logic [31:0] cnt [qit_pkg::NUM_TIMERS];
		err_before = errors;
		// held settings only, nothing moves until the sync write
		for (int n = 0; n < qit_pkg::NUM_TIMERS; n++) begin
			mx[n] = 600 + $urandom % 400;
			setup_timer(n, mx[n], mx[n] / 2, ctrl_word(1, 1, 1, 0, 0, 0));
		end
		bus_write(qit_pkg::REG_SYNC, 32'hf);
		wait_load();
		// back-to-back reads, one cycle apart
		@(posedge clk);
		req_i <= 1'b1;
		we_i <= 1'b0;
		addr_i <= timer_addr(0, qit_pkg::REG_COUNT);
		for (int n = 0; n < qit_pkg::NUM_TIMERS; n++) begin
			@(posedge clk);
			if (n < qit_pkg::NUM_TIMERS - 1)
				addr_i <= timer_addr(n + 1, qit_pkg::REG_COUNT);
			else
				req_i <= 1'b0;
			@(negedge clk);
			check_value("ack in read burst", ack_o, 1'b1);
			cnt[n] = rdata_o;
		end
		// first read sees two steps after load, each later read one more
		for (int n = 0; n < qit_pkg::NUM_TIMERS; n++)
			check_value($sformatf("timer %0d progress", n), cnt[n],
				expected_count(n + 2, mx[n], 1'b1));
		report_test("synchronous start", err_before);
	endtask

	// ==============================
	// main sequence
	// ==============================

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		req_i = 1'b0;
		we_i = 1'b0;
		addr_i = '0;
		wdata_i = '0;
		ext_clk_i = '0;
		ext_gate_i = '0;
		void'($urandom(32'h5e56));
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		test_readback();
		test_one_shot();
		test_irq();
		test_ext_clock();
		test_gating();
		test_sync_start();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+test
src/qit_pkg.sv
src/qit_regs.sv
src/qit_shadow.sv
src/qit_tick.sv
src/qit_counters.sv
src/qit_top.sv
test/qit_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module qit_tb -f project.f -o qit_sim \
	&& ./obj_dir/qit_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "simulation did not build or run"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "result: failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "result: no pass line in log"; exit 1; }
echo "result: passed"
